//--- rtl/dla_pkg.sv
package dla_pkg;

    //////////////////////////////
    // datapath sizes
    localparam int TN              = 4;                  // lanes per word
    localparam int FEATURE_WIDTH   = 8;
    localparam int KERNEL_WIDTH    = 8;
    localparam int BUS_WIDTH       = TN * 8;             // feature, weight and ext bus word
    localparam int BUF_ADDR_WIDTH  = 8;
    localparam int BANK_DEPTH      = 2 ** BUF_ADDR_WIDTH;
    localparam int BANK_WIDTH      = 1;                  // feature bank select
    localparam int EXT_ADDR_WIDTH  = 16;
    localparam int COUNT_WIDTH     = 8;
    localparam int SHIFT_WIDTH     = 4;
    localparam int INSTR_WIDTH     = 64;
    localparam int QUEUE_DEPTH     = 8;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
    localparam int ACC_WIDTH       = 18;                 // four 16b products
    localparam int SCALED_WIDTH    = 16;
    localparam int RESULT_CREDITS  = 4;                  // results allowed in flight
    localparam int CREDIT_WIDTH    = $clog2(RESULT_CREDITS + 1);
    localparam int RSVD_WIDTH      = INSTR_WIDTH - 4 - EXT_ADDR_WIDTH - BUF_ADDR_WIDTH
                                     - COUNT_WIDTH - BANK_WIDTH - SHIFT_WIDTH;

    //////////////////////////////
    // instruction word
    typedef enum logic [3:0] {
        OP_NOP          = 4'd0,
        OP_LOAD_FEATURE = 4'd1,
        OP_LOAD_WEIGHT  = 4'd2,
        OP_COMPUTE      = 4'd3,
        OP_HALT         = 4'd4
    } opcode_e;

    typedef struct packed {
        opcode_e                   opcode;    // top nibble
        logic [EXT_ADDR_WIDTH-1:0] src_addr;  // ext addr on loads, feature addr on compute
        logic [BUF_ADDR_WIDTH-1:0] dst_addr;  // buffer addr on loads, weight addr on compute
        logic [COUNT_WIDTH-1:0]    count;     // words or results
        logic [BANK_WIDTH-1:0]     bank;
        logic [SHIFT_WIDTH-1:0]    shift;
        logic [RSVD_WIDTH-1:0]     reserved;
    } instr_t;

    //////////////////////////////
    // block to block bundles
    typedef struct packed {
        logic [EXT_ADDR_WIDTH-1:0] src_addr;
        logic [BUF_ADDR_WIDTH-1:0] dst_addr;
        logic [COUNT_WIDTH-1:0]    count;
    } load_req_t;

    typedef struct packed {
        logic                      en;
        logic [BANK_WIDTH-1:0]     bank;
        logic [BUF_ADDR_WIDTH-1:0] addr;
        logic [BUS_WIDTH-1:0]      data;
    } buf_wr_t;

    typedef struct packed {
        logic                    valid;
        logic [SCALED_WIDTH-1:0] value;   // signed, saturated
    } result_t;

endpackage

//--- rtl/instr_fetch.sv
module instr_fetch (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_fetch_enable,
    input  logic [dla_pkg::QUEUE_CNT_WIDTH-1:0] i_queue_count,
    output logic [dla_pkg::EXT_ADDR_WIDTH-1:0]  o_instr_addr,
    output logic                                o_instr_rd_en,
    input  logic [dla_pkg::INSTR_WIDTH-1:0]     i_instr_data,
    output logic                                o_queue_wr_en,
    output dla_pkg::instr_t                     o_queue_data
);
    import dla_pkg::*;

    logic                       halted;     // halt already landed
    logic                       halt_seen;  // halt landing now
    logic [QUEUE_CNT_WIDTH-1:0] booked;     // queue entries plus reads in flight
    logic                       can_issue;

    // word shows up one cycle after its read, goes straight to the queue
    assign o_queue_data = instr_t'(i_instr_data);
    assign halt_seen    = o_queue_wr_en && (o_queue_data.opcode == OP_HALT);

    // two reads may be in flight, one issued and one landing
    assign booked    = i_queue_count + QUEUE_CNT_WIDTH'(o_instr_rd_en)
                       + QUEUE_CNT_WIDTH'(o_queue_wr_en);
    assign can_issue = i_fetch_enable && !halted && !halt_seen
                       && (booked < QUEUE_CNT_WIDTH'(QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_instr_addr  <= '0;           // program always starts at 0
            o_instr_rd_en <= 1'b0;
            o_queue_wr_en <= 1'b0;
            halted        <= 1'b0;
        end else begin
            o_instr_rd_en <= can_issue;
            o_queue_wr_en <= o_instr_rd_en;
            // step past the address once its read went out
            o_instr_addr  <= o_instr_addr + EXT_ADDR_WIDTH'(o_instr_rd_en);
            if (halt_seen) begin
                halted <= 1'b1;            // sticky until reset
            end
        end
    end

endmodule

//--- rtl/instr_queue.sv
module instr_queue (
    input  logic                                clk,
    input  logic                                i_reset,
    input  logic                                i_wr_en,
    input  dla_pkg::instr_t                     i_wr_data,
    input  logic                                i_rd_en,
    output dla_pkg::instr_t                     o_rd_data,
    output logic [dla_pkg::QUEUE_CNT_WIDTH-1:0] o_count,
    output logic                                o_empty
);
    import dla_pkg::*;

    instr_t                     mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;

    assign o_empty = (o_count == '0);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
            o_count <= o_count + QUEUE_CNT_WIDTH'(i_wr_en) - QUEUE_CNT_WIDTH'(i_rd_en);
        end
    end

    // popped word valid the cycle after the pop
    always_ff @(posedge clk) begin
        if (i_wr_en) mem[wr_ptr] <= i_wr_data;
        if (i_rd_en) o_rd_data <= mem[rd_ptr];
    end

    // fetcher books a slot per outstanding read
    a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
        i_wr_en |-> (o_count < QUEUE_CNT_WIDTH'(QUEUE_DEPTH)));

    // controller only pops what is there
    a_no_underflow: assert property (@(posedge clk) disable iff (i_reset)
        i_rd_en |-> !o_empty);

endmodule

//--- rtl/layer_controller.sv
module layer_controller (
    input  logic                           clk,
    input  logic                           i_reset,
    input  logic                           i_acc_enable,
    input  logic                           i_queue_empty,
    input  dla_pkg::instr_t                i_queue_data,
    output logic                           o_queue_rd_en,
    output logic                           o_fetch_enable,
    output logic                           o_feature_start,
    output dla_pkg::load_req_t             o_feature_req,
    output logic [dla_pkg::BANK_WIDTH-1:0] o_feature_bank,
    input  logic                           i_feature_done,
    output logic                           o_weight_start,
    output dla_pkg::load_req_t             o_weight_req,
    input  logic                           i_weight_done,
    output logic                           o_compute_start,
    output dla_pkg::instr_t                o_compute_instr,
    input  logic                           i_compute_done,
    output logic                           o_done
);
    import dla_pkg::*;

    typedef enum logic [2:0] {IDLE, POP, DECODE, WAIT_DONE, HALTED} state_e;

    state_e    state;
    state_e    state_next;
    opcode_e   op;
    load_req_t req;
    logic      any_done;

    assign op        = i_queue_data.opcode;   // valid in DECODE
    assign any_done  = i_feature_done || i_weight_done || i_compute_done;

    //////////////////////////////
    // FSM
    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (i_acc_enable) state_next = POP;
            POP:       if (!i_queue_empty) state_next = DECODE;
            DECODE: begin
                case (op)
                    OP_HALT:         state_next = HALTED;
                    OP_LOAD_FEATURE,
                    OP_LOAD_WEIGHT,
                    OP_COMPUTE:      state_next = WAIT_DONE;
                    default:         state_next = POP;    // nop, unknown codes skipped
                endcase
            end
            WAIT_DONE: if (any_done) state_next = POP;    // one instr at a time
            default:   state_next = HALTED;               // stays until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign o_queue_rd_en  = (state == POP) && !i_queue_empty;
    assign o_fetch_enable = (state == IDLE) ? i_acc_enable : (state != HALTED);
    assign o_done         = (state == HALTED);

    //////////////////////////////
    // dispatch
    assign req = '{src_addr: i_queue_data.src_addr,
                   dst_addr: i_queue_data.dst_addr,
                   count:    i_queue_data.count};

    assign o_feature_start = (state == DECODE) && (op == OP_LOAD_FEATURE);
    assign o_weight_start  = (state == DECODE) && (op == OP_LOAD_WEIGHT);
    assign o_compute_start = (state == DECODE) && (op == OP_COMPUTE);
    assign o_feature_req   = req;
    assign o_weight_req    = req;
    assign o_feature_bank  = i_queue_data.bank;
    assign o_compute_instr = i_queue_data;    // engine latches on start

    a_one_start: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0({o_feature_start, o_weight_start, o_compute_start}));

    // engines finish only work handed out
    a_done_expected: assert property (@(posedge clk) disable iff (i_reset)
        any_done |-> (state == WAIT_DONE));

endmodule

//--- rtl/bus_loader.sv
module bus_loader (
    input  logic                               clk,
    input  logic                               i_reset,
    input  logic                               i_start,
    input  dla_pkg::load_req_t                 i_req,
    input  logic [dla_pkg::BANK_WIDTH-1:0]     i_bank,
    output logic [dla_pkg::EXT_ADDR_WIDTH-1:0] o_ext_addr,
    output logic                               o_ext_rd_en,
    input  logic [dla_pkg::BUS_WIDTH-1:0]      i_ext_data,
    output dla_pkg::buf_wr_t                   o_wr,
    output logic                               o_done
);
    import dla_pkg::*;

    logic [COUNT_WIDTH-1:0]    remaining;    // reads still to issue
    logic [BUF_ADDR_WIDTH-1:0] wr_addr;
    logic [BANK_WIDTH-1:0]     bank_q;
    logic                      wr_pending;   // a word is on the bus this cycle
    logic                      busy;

    assign o_ext_rd_en = (remaining != '0);  // one read per cycle

    // pair the returning word with its buffer address
    always_comb begin
        o_wr.en   = wr_pending;
        o_wr.bank = bank_q;
        o_wr.addr = wr_addr;
        o_wr.data = i_ext_data;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            remaining  <= '0;
            wr_pending <= 1'b0;
            busy       <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            wr_pending <= o_ext_rd_en;
            o_done     <= busy && !o_ext_rd_en;  // cycle after last write, count+2 total
            if (i_start) begin
                remaining <= i_req.count;
                busy      <= 1'b1;
            end else if (o_ext_rd_en) begin
                remaining <= remaining - 1'b1;
            end else begin
                busy <= 1'b0;
            end
        end
    end

    // address counters
    always_ff @(posedge clk) begin
        if (i_start) begin
            o_ext_addr <= i_req.src_addr;
            wr_addr    <= i_req.dst_addr;
            bank_q     <= i_bank;
        end else begin
            if (o_ext_rd_en) o_ext_addr <= o_ext_addr + 1'b1;
            if (wr_pending) wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

//--- rtl/buffer_bank_array.sv
module buffer_bank_array #(
    parameter int NUM_BANKS = 2
) (
    input  logic                               clk,
    input  dla_pkg::buf_wr_t                   i_wr,
    input  logic                               i_rd_en,
    input  logic [dla_pkg::BANK_WIDTH-1:0]     i_rd_bank,
    input  logic [dla_pkg::BUF_ADDR_WIDTH-1:0] i_rd_addr,
    output logic [dla_pkg::BUS_WIDTH-1:0]      o_rd_data
);
    import dla_pkg::*;

    logic [BUS_WIDTH-1:0] mem [NUM_BANKS][BANK_DEPTH];

    // one write port, one registered read port, bank picked per access
    always_ff @(posedge clk) begin
        if (i_wr.en && (int'(i_wr.bank) < NUM_BANKS)) begin
            mem[i_wr.bank][i_wr.addr] <= i_wr.data;
        end
        if (i_rd_en && (int'(i_rd_bank) < NUM_BANKS)) begin
            o_rd_data <= mem[i_rd_bank][i_rd_addr];   // data next cycle
        end
    end

endmodule

//--- rtl/dot_product_unit.sv
module dot_product_unit (
    input  logic                               clk,
    input  logic                               i_reset,
    input  logic                               i_start,
    input  dla_pkg::instr_t                    i_instr,
    output logic                               o_feature_rd_en,
    output logic [dla_pkg::BANK_WIDTH-1:0]     o_feature_bank,
    output logic [dla_pkg::BUF_ADDR_WIDTH-1:0] o_feature_addr,
    input  logic [dla_pkg::BUS_WIDTH-1:0]      i_feature_data,
    output logic                               o_weight_rd_en,
    output logic [dla_pkg::BUF_ADDR_WIDTH-1:0] o_weight_addr,
    input  logic [dla_pkg::BUS_WIDTH-1:0]      i_weight_data,
    output dla_pkg::result_t                   o_result,
    input  logic                               i_result_credit,
    output logic                               o_done
);
    import dla_pkg::*;

    logic [CREDIT_WIDTH-1:0]           credits;
    logic [COUNT_WIDTH-1:0]            remaining;   // reads left to issue
    logic [SHIFT_WIDTH-1:0]            shift_q;
    logic                              busy;
    logic                              issue;
    logic                              rd_valid;    // stage 1, buffer data back
    logic                              mac_valid;   // stage 2, sum registered
    logic                              res_valid;   // stage 3
    logic [SCALED_WIDTH-1:0]           res_value;
    logic signed [ACC_WIDTH-1:0]       dot_sum;
    logic signed [ACC_WIDTH-1:0]       acc_q;
    logic signed [ACC_WIDTH-1:0]       shifted;
    logic [ACC_WIDTH-SCALED_WIDTH:0]   top_bits;
    logic [SCALED_WIDTH-1:0]           sat_value;

    //////////////////////////////
    // issue and credits
    assign issue           = (remaining != '0) && (credits != '0);
    assign o_feature_rd_en = issue;
    assign o_weight_rd_en  = issue;
    // last result leaving, nothing behind it
    assign o_done          = busy && (remaining == '0) && !rd_valid && !mac_valid;
    assign o_result        = '{valid: res_valid, value: res_value};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            credits   <= CREDIT_WIDTH'(RESULT_CREDITS);
            remaining <= '0;
            busy      <= 1'b0;
            rd_valid  <= 1'b0;
            mac_valid <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            credits   <= credits - CREDIT_WIDTH'(issue) + CREDIT_WIDTH'(i_result_credit);
            rd_valid  <= issue;
            mac_valid <= rd_valid;
            res_valid <= mac_valid;                     // 3 cycles after issue
            if (i_start) begin
                remaining <= i_instr.count;
                busy      <= 1'b1;
            end else begin
                if (issue) remaining <= remaining - 1'b1;
                if (o_done) busy <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // datapath
    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < TN; i++) begin
            dot_sum += ACC_WIDTH'($signed(i_feature_data[i*FEATURE_WIDTH +: FEATURE_WIDTH])
                                  * $signed(i_weight_data[i*KERNEL_WIDTH +: KERNEL_WIDTH]));
        end
    end

    assign shifted  = acc_q >>> shift_q;                // arithmetic
    assign top_bits = shifted[ACC_WIDTH-1:SCALED_WIDTH-1];

    // clamp to signed 16b
    always_comb begin
        if ((&top_bits) || !(|top_bits)) begin
            sat_value = shifted[SCALED_WIDTH-1:0];
        end else if (shifted[ACC_WIDTH-1]) begin
            sat_value = {1'b1, {(SCALED_WIDTH-1){1'b0}}};
        end else begin
            sat_value = {1'b0, {(SCALED_WIDTH-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_feature_bank <= i_instr.bank;
            o_feature_addr <= i_instr.src_addr[BUF_ADDR_WIDTH-1:0];
            o_weight_addr  <= i_instr.dst_addr;
            shift_q        <= i_instr.shift;           // held for the whole run
        end else if (issue) begin
            o_feature_addr <= o_feature_addr + 1'b1;
            o_weight_addr  <= o_weight_addr + 1'b1;
        end
        if (rd_valid) acc_q <= dot_sum;
        if (mac_valid) res_value <= sat_value;
    end

    // sink gives back at most one credit per result taken
    a_credit_bound: assert property (@(posedge clk) disable iff (i_reset)
        credits <= CREDIT_WIDTH'(RESULT_CREDITS));

endmodule

//--- rtl/dla_top.sv
module dla_top (
    input  logic                               clk,
    input  logic                               i_reset,
    input  logic                               i_acc_enable,
    output logic [dla_pkg::EXT_ADDR_WIDTH-1:0] o_instr_addr,
    output logic                               o_instr_rd_en,
    input  logic [dla_pkg::INSTR_WIDTH-1:0]    i_instr_data,
    output logic [dla_pkg::EXT_ADDR_WIDTH-1:0] o_feature_addr,
    output logic                               o_feature_rd_en,
    input  logic [dla_pkg::BUS_WIDTH-1:0]      i_feature_data,
    output logic [dla_pkg::EXT_ADDR_WIDTH-1:0] o_weight_addr,
    output logic                               o_weight_rd_en,
    input  logic [dla_pkg::BUS_WIDTH-1:0]      i_weight_data,
    output dla_pkg::result_t                   o_result,
    input  logic                               i_result_credit,
    output logic                               o_done
);
    import dla_pkg::*;

    //////////////////////////////
    // fetch and queue
    logic                       fetch_enable;
    logic                       queue_wr_en;
    instr_t                     queue_wr_data;
    logic                       queue_rd_en;
    instr_t                     queue_rd_data;
    logic [QUEUE_CNT_WIDTH-1:0] queue_count;
    logic                       queue_empty;

    // controller to engines
    logic                       feature_start;
    logic                       weight_start;
    logic                       compute_start;
    load_req_t                  feature_req;
    load_req_t                  weight_req;
    logic [BANK_WIDTH-1:0]      feature_bank;
    instr_t                     compute_instr;
    logic                       feature_done;
    logic                       weight_done;
    logic                       compute_done;

    // buffer traffic
    buf_wr_t                    feature_wr;
    buf_wr_t                    weight_wr;
    logic                       fbuf_rd_en;
    logic [BANK_WIDTH-1:0]      fbuf_rd_bank;
    logic [BUF_ADDR_WIDTH-1:0]  fbuf_rd_addr;
    logic [BUS_WIDTH-1:0]       fbuf_rd_data;
    logic                       wbuf_rd_en;
    logic [BUF_ADDR_WIDTH-1:0]  wbuf_rd_addr;
    logic [BUS_WIDTH-1:0]       wbuf_rd_data;

    instr_fetch instr_fetch_inst (
        .clk, .i_reset, .i_fetch_enable(fetch_enable), .i_queue_count(queue_count),
        .o_instr_addr, .o_instr_rd_en, .i_instr_data,
        .o_queue_wr_en(queue_wr_en), .o_queue_data(queue_wr_data)
    );

    instr_queue instr_queue_inst (
        .clk, .i_reset, .i_wr_en(queue_wr_en), .i_wr_data(queue_wr_data),
        .i_rd_en(queue_rd_en), .o_rd_data(queue_rd_data),
        .o_count(queue_count), .o_empty(queue_empty)
    );

    layer_controller layer_controller_inst (
        .clk, .i_reset, .i_acc_enable,
        .i_queue_empty(queue_empty), .i_queue_data(queue_rd_data),
        .o_queue_rd_en(queue_rd_en), .o_fetch_enable(fetch_enable),
        .o_feature_start(feature_start), .o_feature_req(feature_req),
        .o_feature_bank(feature_bank), .i_feature_done(feature_done),
        .o_weight_start(weight_start), .o_weight_req(weight_req),
        .i_weight_done(weight_done),
        .o_compute_start(compute_start), .o_compute_instr(compute_instr),
        .i_compute_done(compute_done), .o_done
    );

    //////////////////////////////
    // loaders and buffers
    bus_loader feature_loader (
        .clk, .i_reset, .i_start(feature_start), .i_req(feature_req), .i_bank(feature_bank),
        .o_ext_addr(o_feature_addr), .o_ext_rd_en(o_feature_rd_en),
        .i_ext_data(i_feature_data), .o_wr(feature_wr), .o_done(feature_done)
    );

    bus_loader weight_loader (
        .clk, .i_reset, .i_start(weight_start), .i_req(weight_req), .i_bank('0),
        .o_ext_addr(o_weight_addr), .o_ext_rd_en(o_weight_rd_en),
        .i_ext_data(i_weight_data), .o_wr(weight_wr), .o_done(weight_done)
    );

    buffer_bank_array #(.NUM_BANKS(2)) feature_banks (
        .clk, .i_wr(feature_wr), .i_rd_en(fbuf_rd_en), .i_rd_bank(fbuf_rd_bank),
        .i_rd_addr(fbuf_rd_addr), .o_rd_data(fbuf_rd_data)
    );

    buffer_bank_array #(.NUM_BANKS(1)) weight_banks (
        .clk, .i_wr(weight_wr), .i_rd_en(wbuf_rd_en), .i_rd_bank('0),
        .i_rd_addr(wbuf_rd_addr), .o_rd_data(wbuf_rd_data)
    );

    dot_product_unit dot_product_unit_inst (
        .clk, .i_reset, .i_start(compute_start), .i_instr(compute_instr),
        .o_feature_rd_en(fbuf_rd_en), .o_feature_bank(fbuf_rd_bank),
        .o_feature_addr(fbuf_rd_addr), .i_feature_data(fbuf_rd_data),
        .o_weight_rd_en(wbuf_rd_en), .o_weight_addr(wbuf_rd_addr),
        .i_weight_data(wbuf_rd_data),
        .o_result, .i_result_credit, .o_done(compute_done)
    );

endmodule

//--- verification/dla_top_tb.sv
module dla_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dla_pkg::*;

    localparam string PATTERN_FILE = "verification/dla_patterns.txt";
    localparam int    MEM_WORDS    = 2 ** EXT_ADDR_WIDTH;

    logic                      clk;
    logic                      i_reset;
    logic                      i_acc_enable;
    logic [EXT_ADDR_WIDTH-1:0] o_instr_addr;
    logic                      o_instr_rd_en;
    logic [INSTR_WIDTH-1:0]    i_instr_data;
    logic [EXT_ADDR_WIDTH-1:0] o_feature_addr;
    logic                      o_feature_rd_en;
    logic [BUS_WIDTH-1:0]      i_feature_data;
    logic [EXT_ADDR_WIDTH-1:0] o_weight_addr;
    logic                      o_weight_rd_en;
    logic [BUS_WIDTH-1:0]      i_weight_data;
    result_t                   o_result;
    logic                      i_result_credit;
    logic                      o_done;

    //////////////////////////////
    // external memory images and expected results
    logic [INSTR_WIDTH-1:0]    imem [MEM_WORDS];
    logic [BUS_WIDTH-1:0]      fmem [MEM_WORDS];
    logic [BUS_WIDTH-1:0]      wmem [MEM_WORDS];
    logic [SCALED_WIDTH-1:0]   expected_q [$];
    int                        n_instr;
    int                        n_words;          // feature plus weight words

    // reads seen mid cycle, answered after the next edge
    logic                      instr_pend = 1'b0;
    logic                      feature_pend = 1'b0;
    logic                      weight_pend = 1'b0;
    logic [EXT_ADDR_WIDTH-1:0] instr_pend_addr;
    logic [EXT_ADDR_WIDTH-1:0] feature_pend_addr;
    logic [EXT_ADDR_WIDTH-1:0] weight_pend_addr;

    int                        result_count = 0;
    int                        owed_credits = 0;
    int                        credits_returned = 0;
    int                        cycle_count = 0;
    int                        cycle_limit = 0;
    logic                      done_seen = 1'b0;
    int unsigned               seed_value;

    dla_top dla_top_inst (
        .clk, .i_reset, .i_acc_enable,
        .o_instr_addr, .o_instr_rd_en, .i_instr_data,
        .o_feature_addr, .o_feature_rd_en, .i_feature_data,
        .o_weight_addr, .o_weight_rd_en, .i_weight_data,
        .o_result, .i_result_credit, .o_done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s (expected %0h, got %0h)", $time, msg, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic load_patterns();
        int                        fd;
        int                        fields;
        string                     line;
        byte                       tag;
        logic [EXT_ADDR_WIDTH-1:0] addr;
        logic [63:0]               word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;                 // unmapped instructions read as nop
            fmem[i] = '0;
            wmem[i] = '0;
        end
        n_instr = 0;
        n_words = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            $display("=== FAIL ===");
            $fatal(1, "no pattern file");
        end
        while (!$feof(fd)) begin
            fields = $fgets(line, fd);
            if (fields == 0) continue;                              // end of file
            if (line.len() < 3 || line.getc(0) == "#") continue;   // comment or blank
            fields = $sscanf(line, "%c %h %h", tag, addr, word);
            case (tag)
                "I": begin
                    imem[addr] = word;
                    n_instr++;
                end
                "F": begin
                    fmem[addr] = word[BUS_WIDTH-1:0];
                    n_words++;
                end
                "W": begin
                    wmem[addr] = word[BUS_WIDTH-1:0];
                    n_words++;
                end
                "E": expected_q.push_back(word[SCALED_WIDTH-1:0]);  // addr is just the index
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // memory models and credit return
    initial begin
        seed_value = $urandom(46161);
        forever begin
            @(posedge clk);
            #2;
            i_instr_data   = instr_pend   ? imem[instr_pend_addr]   : '0;
            i_feature_data = feature_pend ? fmem[feature_pend_addr] : '0;
            i_weight_data  = weight_pend  ? wmem[weight_pend_addr]  : '0;
            if (owed_credits > 0 && ($urandom % 3) == 0) begin   // withheld at random
                i_result_credit = 1'b1;
                owed_credits--;
                credits_returned++;
            end else begin
                i_result_credit = 1'b0;
            end
        end
    end

    // sample everything mid cycle
    always @(negedge clk) begin
        instr_pend        = o_instr_rd_en;
        instr_pend_addr   = o_instr_addr;
        feature_pend      = o_feature_rd_en;
        feature_pend_addr = o_feature_addr;
        weight_pend       = o_weight_rd_en;
        weight_pend_addr  = o_weight_addr;
        if (!i_reset && o_result.valid === 1'b1) begin
            check_equal(result_count < expected_q.size(), 1, "result beyond the program");
            check_equal(o_result.value, expected_q[result_count], $sformatf("result %0d",
                        result_count));
            result_count++;
            owed_credits++;
            check_equal(result_count - credits_returned <= RESULT_CREDITS, 1,
                        "more results outstanding than credits allow");
        end
        if (done_seen) check_equal(o_done, 1'b1, "o_done dropped after halt");
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // main sequence
    initial begin
        i_reset         = 1'b1;
        i_acc_enable    = 1'b0;
        i_result_credit = 1'b0;
        i_instr_data    = '0;
        i_feature_data  = '0;
        i_weight_data   = '0;
        load_patterns();
        cycle_limit = 20 * (n_instr + n_words + expected_q.size()) + 200;

        repeat (3) @(posedge clk);
        #2 i_reset = 1'b0;

        // nothing moves before the start pulse
        repeat (3) begin
            @(negedge clk);
            check_equal({o_instr_rd_en, o_feature_rd_en, o_weight_rd_en, o_result.valid, o_done},
                        5'b0, "outputs active before start");
        end

        @(posedge clk);
        #2 i_acc_enable = 1'b1;
        @(posedge clk);
        #2 i_acc_enable = 1'b0;

        while (o_done !== 1'b1) @(negedge clk);   // wait for the halt
        done_seen = 1'b1;
        check_equal(result_count, expected_q.size(), "result count at halt");

        // instruction after halt must never run
        repeat (40) @(negedge clk);
        check_equal(result_count, expected_q.size(), "result count after halt");

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- dla_top.f
rtl/dla_pkg.sv
rtl/instr_fetch.sv
rtl/instr_queue.sv
rtl/layer_controller.sv
rtl/bus_loader.sv
rtl/buffer_bank_array.sv
rtl/dot_product_unit.sv
rtl/dla_top.sv
verification/dla_top_tb.sv

//--- verification/dla_patterns.txt
# columns: tag, hex address, hex word
# I instruction, F feature word, W weight word, E expected result (address is its index)
I 0000 1000000030000000
I 0001 1001000028000000
I 0002 1002008020000000
I 0003 2000000060000000
I 0004 0000000000000000
I 0005 3000000030000000
I 0006 3000001029000000
I 0007 3000803020000000
I 0008 3000804020800000
I 0009 3000804010000000
I 000a 4000000000000000
I 000b 3000000030000000
F 0000 04030201
F 0001 0605FEFF
F 0002 EC14F60A
F 0010 08E73264
F 0011 463CCE9C
F 0020 7F7F7F7F
F 0021 80808080
W 0000 01010101
W 0001 FB04FD02
W 0002 0203FF07
W 0003 7F7F7F7F
W 0004 80808080
W 0005 80808080
E 0000 000A
E 0001 FFFA
E 0002 0064
E 0003 FFE9
E 0004 FFAD
E 0005 7FFF
E 0006 7FFF
E 0007 8100
E 0008 7FFF
E 0009 8000
